// File: design/lcd_pkg.sv
package lcd_pkg;

	// ============================================================
	// message table
	// ============================================================

	localparam int MSG_LEN = 26;
	localparam int INDEX_W = $clog2(MSG_LEN);

	// ============================================================
	// HD44780 command codes
	// ============================================================

	localparam logic [7:0] CMD_FUNCTION_SET = 8'h38;
	localparam logic [7:0] CMD_ENTRY_MODE   = 8'h06;
	localparam logic [7:0] CMD_DISPLAY_ON   = 8'h0C;
	localparam logic [7:0] CMD_CLEAR        = 8'h01;
	localparam logic [7:0] CMD_HOME         = 8'h02;
	localparam logic [7:0] CMD_LINE2        = 8'hC0;

	// ============================================================
	// timing
	// ============================================================

	// 1000 clocks is 20 us at 50 MHz.
	localparam int CLK_DIV_DEFAULT = 1000;
	localparam int CLK_DIV_W       = 16;

	// clear and return-home need well over a millisecond on the panel.
	localparam int SHORT_WAIT_TICKS = 3;
	localparam int LONG_WAIT_TICKS  = 80;
	localparam int WAIT_W           = 7;

	// ============================================================
	// sequencer states
	// ============================================================

	localparam logic [1:0] ST_SETUP  = 2'd0;
	localparam logic [1:0] ST_STROBE = 2'd1;
	localparam logic [1:0] ST_HOLD   = 2'd2;
	localparam logic [1:0] ST_WAIT   = 2'd3;

endpackage

// File: design/lcd_bus_if.sv
interface lcd_bus_if;

	logic       rs;
	logic       rw;
	logic       en;
	logic [7:0] data;

	modport driver (
		output rs,
		output rw,
		output en,
		output data
	);

	modport panel (
		input rs,
		input rw,
		input en,
		input data
	);

endinterface

// File: design/lcd_tick_gen.sv
module lcd_tick_gen (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [lcd_pkg::CLK_DIV_W-1:0] clk_div,
	output logic                          tick
);

	import lcd_pkg::*;

	logic [CLK_DIV_W-1:0] cnt;

	// the counter sits at zero out of reset, so the first reload happens on
	// the first clock and the first tick lands clk_div clocks later.
	// tick is registered from the cycle before the counter reaches zero.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt  <= '0;
			tick <= 1'b0;
		end else begin
			if (cnt == '0) begin
				cnt <= clk_div - 1'b1;
			end else begin
				cnt <= cnt - 1'b1;
			end
			tick <= (cnt == CLK_DIV_W'(1));
		end
	end

endmodule

// File: design/lcd_message_rom.sv
module lcd_message_rom (
	input  logic [lcd_pkg::INDEX_W-1:0] index,
	output logic                        entry_rs,
	output logic [7:0]                  entry_byte
);

	import lcd_pkg::*;

	// rs low is a command, rs high is a character for DDRAM.
	always_comb begin
		entry_rs   = 1'b1;
		entry_byte = CMD_HOME;
		case (index)
			// ============================================================
			// initialisation
			// ============================================================
			5'd0:  begin entry_rs = 1'b0; entry_byte = CMD_FUNCTION_SET; end
			5'd1:  begin entry_rs = 1'b0; entry_byte = CMD_ENTRY_MODE; end
			5'd2:  begin entry_rs = 1'b0; entry_byte = CMD_DISPLAY_ON; end
			5'd3:  begin entry_rs = 1'b0; entry_byte = CMD_CLEAR; end
			// ============================================================
			// line one
			// ============================================================
			5'd4:  entry_byte = "H";
			5'd5:  entry_byte = "o";
			5'd6:  entry_byte = "l";
			5'd7:  entry_byte = "a";
			5'd8:  entry_byte = " ";
			5'd9:  entry_byte = "B";
			5'd10: entry_byte = "i";
			5'd11: entry_byte = "e";
			5'd12: entry_byte = "n";
			5'd13: entry_byte = "v";
			5'd14: entry_byte = "e";
			5'd15: entry_byte = "n";
			5'd16: entry_byte = "i";
			5'd17: entry_byte = "d";
			5'd18: entry_byte = "o";
			5'd19: entry_byte = "s";
			// ============================================================
			// line two
			// ============================================================
			5'd20: begin entry_rs = 1'b0; entry_byte = CMD_LINE2; end
			5'd21: entry_byte = "1";
			5'd22: entry_byte = "2";
			5'd23: entry_byte = "3";
			5'd24: entry_byte = "4";
			5'd25: entry_byte = "5";
			// unused indices park the cursor, which is harmless.
			default: begin
				entry_rs   = 1'b0;
				entry_byte = CMD_HOME;
			end
		endcase
	end

endmodule

// File: design/lcd_sequencer.sv
module lcd_sequencer (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        tick,
	output logic [lcd_pkg::INDEX_W-1:0] index,
	input  logic                        entry_rs,
	input  logic [7:0]                  entry_byte,
	lcd_bus_if.driver                   bus
);

	import lcd_pkg::*;

	logic [1:0]        state;
	logic [WAIT_W-1:0] wait_cnt;
	logic              rs_r;
	logic [7:0]        data_r;
	logic              long_wait;

	// clear and return-home are the two slow commands.
	assign long_wait = !rs_r && ((data_r == CMD_CLEAR) || (data_r == CMD_HOME));

	// ============================================================
	// write FSM, advancing one step per tick
	// ============================================================

	// out of reset the FSM sits at the last tick of a wait, so the first
	// tick loads entry 0 and starts its setup phase.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_WAIT;
			wait_cnt <= '0;
			index    <= '0;
			rs_r     <= 1'b0;
			data_r   <= '0;
		end else if (tick) begin
			case (state)
				ST_SETUP: begin
					state <= ST_STROBE;
				end
				ST_STROBE: begin
					state <= ST_HOLD;
				end
				ST_HOLD: begin
					state <= ST_WAIT;
					if (long_wait) begin
						wait_cnt <= WAIT_W'(LONG_WAIT_TICKS - 1);
					end else begin
						wait_cnt <= WAIT_W'(SHORT_WAIT_TICKS - 1);
					end
					// the bus lines are registered, so the table may move on now.
					if (index == INDEX_W'(MSG_LEN - 1)) begin
						index <= '0;
					end else begin
						index <= index + 1'b1;
					end
				end
				default: begin
					if (wait_cnt == '0) begin
						state  <= ST_SETUP;
						rs_r   <= entry_rs;
						data_r <= entry_byte;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
			endcase
		end
	end

	// ============================================================
	// bus outputs
	// ============================================================

	// write-only panel; the busy flag is never read.
	assign bus.rw   = 1'b0;
	assign bus.en   = (state == ST_STROBE);
	assign bus.rs   = rs_r;
	assign bus.data = data_r;

endmodule

// File: design/lcd_top.sv
module lcd_top #(
	parameter int CLK_DIV = lcd_pkg::CLK_DIV_DEFAULT
) (
	input  logic       clk,
	input  logic       rst_n,
	output logic       lcd_rs,
	output logic       lcd_rw,
	output logic       lcd_en,
	output logic [7:0] lcd_data
);

	import lcd_pkg::*;

	logic               tick;
	logic [INDEX_W-1:0] index;
	logic               entry_rs;
	logic [7:0]         entry_byte;

	lcd_bus_if bus_if ();

	lcd_tick_gen tick_gen_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.clk_div (CLK_DIV_W'(CLK_DIV)),
		.tick    (tick)
	);

	lcd_message_rom rom_i (
		.index      (index),
		.entry_rs   (entry_rs),
		.entry_byte (entry_byte)
	);

	lcd_sequencer seq_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.tick       (tick),
		.index      (index),
		.entry_rs   (entry_rs),
		.entry_byte (entry_byte),
		.bus        (bus_if.driver)
	);

	assign lcd_rs   = bus_if.rs;
	assign lcd_rw   = bus_if.rw;
	assign lcd_en   = bus_if.en;
	assign lcd_data = bus_if.data;

endmodule

// File: sim/lcd_bus_assertions.sv
module lcd_bus_assertions (
	input logic       clk,
	input logic       rst_n,
	input logic       rs,
	input logic       rw,
	input logic       en,
	input logic [7:0] data
);

	timeunit 1ns;
	timeprecision 100ps;

	// ============================================================
	// write strobe protocol
	// ============================================================

	rw_never_high: assert property (@(posedge clk) rw == 1'b0)
		else $error("rw went high on a write-only bus");

	// this also covers the clock at which en falls.
	lines_stable_while_en: assert property (@(posedge clk) disable iff (!rst_n)
		$past(en) |-> $stable(rs) && $stable(data))
		else $error("rs or data changed while en was high");

	lines_stable_after_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(en) |=> $stable(rs) && $stable(data))
		else $error("rs or data changed in the cycle after en fell");

	en_low_in_reset: assert property (@(posedge clk) !rst_n |-> !en)
		else $error("en was high during reset");

endmodule

bind lcd_sequencer lcd_bus_assertions bus_assertions_i (
	.clk   (clk),
	.rst_n (rst_n),
	.rs    (bus.rs),
	.rw    (bus.rw),
	.en    (bus.en),
	.data  (bus.data)
);

// File: sim/lcd_top_tb.sv
module lcd_top_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_DIV      = 4;
	localparam int MSG_ROWS     = 26;
	localparam int WRAP_ROWS    = 4;
	localparam int RISE_TIMEOUT = 120 * CLK_DIV;

	logic       clk;
	logic       rst_n;
	logic       lcd_rs;
	logic       lcd_rw;
	logic       lcd_en;
	logic [7:0] lcd_data;

	int value_errs;
	int timing_errs;
	int timeouts;

	// ============================================================
	// expected writes with one row per table entry
	// ============================================================

	logic exp_rs [MSG_ROWS] = '{
		1'b0, 1'b0, 1'b0, 1'b0,
		1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1,
		1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1,
		1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1
	};

	logic [7:0] exp_data [MSG_ROWS] = '{
		8'h38, 8'h06, 8'h0C, 8'h01,
		"H", "o", "l", "a", " ", "B", "i", "e",
		"n", "v", "e", "n", "i", "d", "o", "s",
		8'hC0, "1", "2", "3", "4", "5"
	};

	// ticks from the rise of en on this write to the rise on the next one.
	int exp_ticks [MSG_ROWS] = '{
		6, 6, 6, 83,
		6, 6, 6, 6, 6, 6, 6, 6,
		6, 6, 6, 6, 6, 6, 6, 6,
		6, 6, 6, 6, 6, 6
	};

	lcd_top #(
		.CLK_DIV (CLK_DIV)
	) lcd_top_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.lcd_rs   (lcd_rs),
		.lcd_rw   (lcd_rw),
		.lcd_en   (lcd_en),
		.lcd_data (lcd_data)
	);

	always #5 clk = ~clk;

	task automatic check_idle_bus();
		assert (lcd_en === 1'b0 && lcd_rs === 1'b0 && lcd_rw === 1'b0 && lcd_data === 8'h00)
		else begin
			value_errs++;
			$display("ERR %0t: bus not idle around reset, en=%b rs=%b rw=%b data=%h",
				$time, lcd_en, lcd_rs, lcd_rw, lcd_data);
		end
	endtask

	task automatic check_rw_low();
		assert (lcd_rw === 1'b0)
		else begin
			value_errs++;
			$display("ERR %0t: rw is %b, expected 0", $time, lcd_rw);
		end
	endtask

	task automatic wait_en_high(output int clks, output bit timed_out);
		int n;
		n = 0;
		while (lcd_en !== 1'b1 && n < RISE_TIMEOUT) begin
			@(negedge clk);
			n++;
			check_rw_low();
		end
		timed_out = (lcd_en !== 1'b1);
		clks = n;
	endtask

	task automatic measure_en_high(output int clks, output bit timed_out);
		int n;
		n = 0;
		while (lcd_en === 1'b1 && n < RISE_TIMEOUT) begin
			check_rw_low();
			n++;
			@(negedge clk);
		end
		timed_out = (lcd_en === 1'b1);
		clks = n;
	endtask

	// called on the first falling clock edge after en falls, while the hold phase keeps the lines.
	task automatic check_write(input logic [4:0] row, input int high_clks);
		assert (lcd_rs === exp_rs[row] && lcd_data === exp_data[row])
		else begin
			value_errs++;
			$display("ERR %0t: entry %0d wrote rs=%b data=%h, expected rs=%b data=%h",
				$time, row, lcd_rs, lcd_data, exp_rs[row], exp_data[row]);
		end
		assert (high_clks == CLK_DIV)
		else begin
			timing_errs++;
			$display("ERR %0t: entry %0d had en high for %0d clocks, expected %0d",
				$time, row, high_clks, CLK_DIV);
		end
	endtask

	task automatic check_gap(input logic [4:0] prev_row, input int gap_clks);
		int expected;
		expected = exp_ticks[prev_row] * CLK_DIV;
		assert (gap_clks == expected)
		else begin
			timing_errs++;
			$display("ERR %0t: %0d clocks between en rises after entry %0d, expected %0d",
				$time, gap_clks, prev_row, expected);
		end
	endtask

	task automatic report_and_finish();
		$display("errors: value %0d, timing %0d, timeouts %0d",
			value_errs, timing_errs, timeouts);
		if (value_errs == 0 && timing_errs == 0 && timeouts == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	endtask

	// ============================================================
	// reset, then capture every write and one more pass of the init rows
	// ============================================================

	initial begin
		int         low_clks;
		int         high_clks;
		int         prev_high;
		bit         timed_out;
		logic [4:0] row;
		logic [4:0] prev_row;

		clk         = 1'b0;
		rst_n       = 1'b0;
		value_errs  = 0;
		timing_errs = 0;
		timeouts    = 0;
		timed_out   = 1'b0;
		prev_high   = 0;
		prev_row    = '0;

		repeat (3) begin
			@(negedge clk);
			check_idle_bus();
		end
		rst_n = 1'b1;
		@(negedge clk);
		check_idle_bus();

		for (int i = 0; i < MSG_ROWS + WRAP_ROWS && !timed_out; i++) begin
			row = 5'(i % MSG_ROWS);
			wait_en_high(low_clks, timed_out);
			if (timed_out) begin
				timeouts++;
				$display("Timeout: en did not rise within %0d clocks for write %0d.",
					RISE_TIMEOUT, i);
			end else begin
				if (i > 0) begin
					check_gap(prev_row, prev_high + low_clks);
				end
				measure_en_high(high_clks, timed_out);
				if (timed_out) begin
					timeouts++;
					$display("Timeout: en stayed high for more than %0d clocks on write %0d.",
						RISE_TIMEOUT, i);
				end else begin
					check_write(row, high_clks);
					prev_high = high_clks;
					prev_row  = row;
				end
			end
		end

		report_and_finish();
	end

endmodule

// File: filelist.f
design/lcd_pkg.sv
design/lcd_bus_if.sv
design/lcd_tick_gen.sv
design/lcd_message_rom.sv
design/lcd_sequencer.sv
design/lcd_top.sv
sim/lcd_bus_assertions.sv
sim/lcd_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the LCD testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --timescale 1ns/100ps --top-module lcd_top_tb \
	-f filelist.f --Mdir "$BUILD_DIR" -o lcd_top_tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status."
	exit 1
fi

"./$BUILD_DIR/lcd_top_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

grep -q "Result: FAILED" "$LOG"
status=$?
if [ $status -eq 0 ]; then
	exit 1
elif [ $status -ne 1 ]; then
	echo "Could not search the log file $LOG."
	exit 1
fi
exit 0
